// ==== Makefile ====
# Verilator build and run for the LCD controller testbench

VERILATOR ?= verilator
TOP       ?= tb_lcd_ctrl
FILELIST  ?= lcd_ctrl.f
BUILD_DIR ?= build
VFLAGS    ?= --binary --timing -Wno-fatal -j 0
PASS_MSG  ?= Test completed successfully

SIM_BIN  = $(BUILD_DIR)/$(TOP)
SOURCES  = $(shell grep -v '^+' $(FILELIST))
HEADERS  = $(wildcard include/*.svh)

.PHONY: all compile run clean

all: run

compile: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES) $(HEADERS)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) \
		--Mdir $(BUILD_DIR) -o $(TOP)

# The simulation passes only if its output holds the pass message
run: compile
	@out="$$(./$(SIM_BIN))"; status=$$?; \
	echo "$$out"; \
	if [ $$status -ne 0 ]; then \
		echo "Simulator exited with status $$status"; exit 1; \
	fi; \
	if echo "$$out" | grep -q "$(PASS_MSG)"; then \
		exit 0; \
	else \
		echo "Pass message not found in simulation output"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// ==== include/lcd_params.svh ====
`ifndef LCD_PARAMS_SVH
`define LCD_PARAMS_SVH

// --------------------------------------------------------------------------
// Delay counts for a 24 MHz clock, one cycle is about 41.667 ns
// --------------------------------------------------------------------------

`define LCD_CYC_W           20          // Width of every delay counter

`define LCD_E_HIGH_CYC      6           // Enable pulse of ~250 ns
                                        // Also the wait after a data write

`define LCD_WAIT_CMD_CYC    1008        // Ordinary instruction, 42 us
`define LCD_WAIT_INIT_CYC   2400        // Repeated function set, 100 us
`define LCD_WAIT_CLEAR_CYC  39360       // Display clear, 1.64 ms
`define LCD_WAIT_FUNC_CYC   98400       // First function set, 4.1 ms

`define LCD_POWER_ON_CYC    360000      // Power-on settle, 15 ms

// --------------------------------------------------------------------------
// Init command bytes
// --------------------------------------------------------------------------

`define LCD_CMD_SETUP       8'b0011_1000 // 8-bit bus, 2 lines, 5x7 font
`define LCD_CMD_DISP_OFF    8'b0000_1000 // Display, cursor and blink off
`define LCD_CMD_CLEAR       8'b0000_0001 // Clear DDRAM, cursor home
`define LCD_CMD_ENTRY       8'b0000_0110 // Cursor increments, no shift
`define LCD_CMD_DISP_ON     8'b0000_1100 // Display on, cursor off

// Bit layout of the function set byte, for reference
//   [5] function set opcode
//   [4] DL, 1 = 8-bit interface
//   [3] N, 1 = two display lines
//   [2] F, 0 = 5x7 dot font

`endif

// ==== lcd_ctrl.f ====
+incdir+include
logic/lcd_pkg.sv
logic/lcd_init_seq.sv
logic/lcd_bus_cycle.sv
logic/lcd_ctrl_top.sv
verif/tb_lcd_ctrl.sv

// ==== logic/lcd_bus_cycle.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_bus_cycle (
	input  logic                 CLK,
	input  logic                 RST,
	input  logic                 cmd_start,   // One-cycle request
	input  logic                 cmd_rs,
	input  lcd_pkg::lcd_byte_t   cmd_byte,
	input  lcd_pkg::wait_class_t cmd_wait,
	output logic                 cmd_done,    // One-cycle completion
	output logic                 lcd_rs,
	output logic                 lcd_e,
	output lcd_pkg::lcd_byte_t   lcd_db
);
	import lcd_pkg::*;

	bus_state_t  state;
	lcd_cyc_t    cnt;                         // Shared down-counter
	lcd_cyc_t    exec_cyc;                    // Wait length of latched class
	lcd_byte_t   byte_q;                      // Latched command byte
	wait_class_t wait_q;                      // Latched wait class

	// ------------------------------------------------------------------------
	// Wait class to cycle count
	// ------------------------------------------------------------------------

	always_comb begin
		case (wait_q)
			WAIT_SHORT: exec_cyc = lcd_cyc_t'(`LCD_E_HIGH_CYC);
			WAIT_CMD:   exec_cyc = lcd_cyc_t'(`LCD_WAIT_CMD_CYC);
			WAIT_INIT:  exec_cyc = lcd_cyc_t'(`LCD_WAIT_INIT_CYC);
			WAIT_FUNC:  exec_cyc = lcd_cyc_t'(`LCD_WAIT_FUNC_CYC);
			WAIT_CLEAR: exec_cyc = lcd_cyc_t'(`LCD_WAIT_CLEAR_CYC);
			default:    exec_cyc = lcd_cyc_t'(`LCD_WAIT_FUNC_CYC); // Longest wait
		endcase
	end

	// Command payload, held for the whole bus cycle
	always_ff @(posedge CLK) begin
		if (cmd_start && state == BUS_IDLE) begin
			byte_q <= cmd_byte;
			wait_q <= cmd_wait;
		end
	end

	assign cmd_done = (state == BUS_DONE);

	// ------------------------------------------------------------------------
	// Bus cycle FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (RST) begin
			state  <= BUS_IDLE;
			cnt    <= '0;
			lcd_rs <= 1'b0;
			lcd_e  <= 1'b0;
			lcd_db <= '0;
		end else begin
			case (state)
				BUS_IDLE: begin
					if (cmd_start) begin
						lcd_rs <= cmd_rs;             // RS settles while E is low
						state  <= BUS_SETUP;
					end
				end
				BUS_SETUP: begin
					lcd_e  <= 1'b1;                 // Rising edge of enable
					lcd_db <= byte_q;               // Byte valid for whole pulse
					cnt    <= lcd_cyc_t'(`LCD_E_HIGH_CYC - 1);
					state  <= BUS_STROBE;
				end
				BUS_STROBE: begin
					if (cnt == '0) begin
						lcd_e <= 1'b0;                // LCD latches on the fall
						cnt   <= exec_cyc - 1'b1;
						state <= BUS_EXEC;
					end else begin
						cnt <= cnt - 1'b1;
					end
				end
				BUS_EXEC: begin
					if (cnt == '0)                  // DB and RS keep their values
						state <= BUS_DONE;
					else
						cnt <= cnt - 1'b1;
				end
				BUS_DONE: begin
					state <= BUS_IDLE;              // cmd_done high this cycle
				end
				default: begin
					lcd_e <= 1'b0;
					state <= BUS_IDLE;
				end
			endcase
		end
	end

	// Cycle budget per command
	//   1 setup + LCD_E_HIGH_CYC strobe + exec_cyc wait + 1 done

endmodule

// ==== logic/lcd_ctrl_top.sv ====
`timescale 1ns/1ps

module lcd_ctrl_top (
	input  logic               CLK,
	input  logic               RST,
	input  lcd_pkg::lcd_byte_t data,          // Host byte
	input  lcd_pkg::lcd_oper_t oper,          // Host operation
	input  logic               enb,           // Host strobe
	output logic               rdy,           // Ready for a request
	output logic               lcd_rs,        // Register select
	output logic               lcd_rw,        // Read/write, write only
	output logic               lcd_e,         // Enable strobe
	output lcd_pkg::lcd_byte_t lcd_db         // 8-bit data bus
);
	import lcd_pkg::*;

	// ------------------------------------------------------------------------
	// Sequencer to bus engine command port
	// ------------------------------------------------------------------------

	logic        cmd_start;
	logic        cmd_rs;
	lcd_byte_t   cmd_byte;
	wait_class_t cmd_wait;
	logic        cmd_done;

	assign lcd_rw = 1'b0;                     // Busy flag never read

	// Power-on wait, init table and host requests
	lcd_init_seq lcd_init_seq_inst (
		.CLK       (CLK),
		.RST       (RST),
		.data      (data),
		.oper      (oper),
		.enb       (enb),
		.cmd_done  (cmd_done),
		.rdy       (rdy),
		.cmd_start (cmd_start),
		.cmd_rs    (cmd_rs),
		.cmd_byte  (cmd_byte),
		.cmd_wait  (cmd_wait)
	);

	// Strobes, data bus and execution wait
	lcd_bus_cycle lcd_bus_cycle_inst (
		.CLK       (CLK),
		.RST       (RST),
		.cmd_start (cmd_start),
		.cmd_rs    (cmd_rs),
		.cmd_byte  (cmd_byte),
		.cmd_wait  (cmd_wait),
		.cmd_done  (cmd_done),
		.lcd_rs    (lcd_rs),
		.lcd_e     (lcd_e),
		.lcd_db    (lcd_db)
	);

endmodule

// ==== logic/lcd_init_seq.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module lcd_init_seq (
	input  logic                 CLK,
	input  logic                 RST,
	input  lcd_pkg::lcd_byte_t   data,        // Host byte
	input  lcd_pkg::lcd_oper_t   oper,        // Host operation
	input  logic                 enb,         // Host strobe
	input  logic                 cmd_done,    // From bus engine
	output logic                 rdy,         // Idle and accepting
	output logic                 cmd_start,   // One-cycle command pulse
	output logic                 cmd_rs,      // 1 data, 0 instruction
	output lcd_pkg::lcd_byte_t   cmd_byte,
	output lcd_pkg::wait_class_t cmd_wait
);
	import lcd_pkg::*;

	localparam int INIT_LAST = 8;             // Index of the final table entry

	seq_state_t            state;
	logic [`LCD_CYC_W-1:0] pwr_cnt;           // Power-on wait counter
	logic [3:0]            init_idx;          // Init table position
	lcd_byte_t             tbl_byte;          // Table output
	wait_class_t           tbl_wait;
	lcd_byte_t             host_byte;         // Captured host request
	logic                  host_rs;
	logic                  accept;            // Request taken this edge
	logic                  host_sel;          // Host command on the cmd port

	// ------------------------------------------------------------------------
	// Init table
	// ------------------------------------------------------------------------

	always_comb begin
		case (init_idx)
			4'd0: begin
				tbl_byte = `LCD_CMD_SETUP;        // First function set
				tbl_wait = WAIT_FUNC;
			end
			4'd1, 4'd2, 4'd3: begin
				tbl_byte = `LCD_CMD_SETUP;        // Repeated function sets
				tbl_wait = WAIT_INIT;
			end
			4'd4: begin
				tbl_byte = `LCD_CMD_DISP_OFF;
				tbl_wait = WAIT_CMD;
			end
			4'd5: begin
				tbl_byte = `LCD_CMD_CLEAR;
				tbl_wait = WAIT_CLEAR;
			end
			4'd6: begin
				tbl_byte = `LCD_CMD_ENTRY;
				tbl_wait = WAIT_CMD;
			end
			4'd7: begin
				tbl_byte = `LCD_CMD_DISP_ON;
				tbl_wait = WAIT_CMD;
			end
			default: begin
				tbl_byte = `LCD_CMD_CLEAR;        // Final clear, entry 8
				tbl_wait = WAIT_CLEAR;
			end
		endcase
	end

	// ------------------------------------------------------------------------
	// Host side
	// ------------------------------------------------------------------------

	assign rdy    = (state == SEQ_IDLE);
	assign accept = rdy && enb && (oper != OPER_NONE);

	// Request payload, taken on the accepting edge
	always_ff @(posedge CLK) begin
		if (accept) begin
			host_byte <= data;
			host_rs   <= (oper == OPER_DATA);     // Characters go with RS high
		end
	end

	// Command port mux, host regs while a host write is in flight
	assign host_sel = (state == SEQ_HOST_WAIT);
	assign cmd_byte = host_sel ? host_byte : tbl_byte;
	assign cmd_rs   = host_sel & host_rs;     // Init commands always RS low

	always_comb begin
		if (!host_sel)
			cmd_wait = tbl_wait;
		else if (host_rs)
			cmd_wait = WAIT_SHORT;                // Character write
		else
			cmd_wait = WAIT_CMD;                  // Host instruction, 42 us
	end

	// ------------------------------------------------------------------------
	// Sequencer FSM
	// ------------------------------------------------------------------------

	always_ff @(posedge CLK) begin
		if (RST) begin
			state     <= SEQ_POWER;
			pwr_cnt   <= '0;
			init_idx  <= '0;
			cmd_start <= 1'b0;
		end else begin
			cmd_start <= 1'b0;                    // Pulse by default
			case (state)
				SEQ_POWER: begin
					if (pwr_cnt == `LCD_CYC_W'(`LCD_POWER_ON_CYC - 1)) begin
						pwr_cnt   <= '0;
						init_idx  <= '0;              // Start of table
						cmd_start <= 1'b1;
						state     <= SEQ_INIT_ISSUE;
					end else begin
						pwr_cnt <= pwr_cnt + 1'b1;
					end
				end
				SEQ_INIT_ISSUE: begin
					state <= SEQ_INIT_WAIT;           // Engine has latched the entry
				end
				SEQ_INIT_WAIT: begin
					if (cmd_done) begin
						if (init_idx == INIT_LAST[3:0]) begin
							state <= SEQ_IDLE;          // Init finished, rdy next cycle
						end else begin
							init_idx  <= init_idx + 1'b1;
							cmd_start <= 1'b1;          // Next entry right away
							state     <= SEQ_INIT_ISSUE;
						end
					end
				end
				SEQ_IDLE: begin
					if (accept) begin
						if (oper == OPER_REINIT) begin
							pwr_cnt <= '0;              // Full power-on wait again
							state   <= SEQ_POWER;
						end else begin
							cmd_start <= 1'b1;
							state     <= SEQ_HOST_WAIT;
						end
					end
				end
				SEQ_HOST_WAIT: begin
					if (cmd_done)
						state <= SEQ_IDLE;
				end
				default: begin
					state <= SEQ_POWER;
				end
			endcase
		end
	end

endmodule

// ==== logic/lcd_pkg.sv ====
`include "lcd_params.svh"

package lcd_pkg;

	typedef logic [7:0] lcd_byte_t;              // Bus byte holding a char or an instr
	typedef logic [`LCD_CYC_W-1:0] lcd_cyc_t;    // Delay count in clocks

	// Host operation code as driven on the oper pins
	typedef enum logic [1:0] {
		OPER_NONE   = 2'd0,                      // Ignored
		OPER_DATA   = 2'd1,                      // Write one character
		OPER_INSTR  = 2'd2,                      // Write one instruction
		OPER_REINIT = 2'd3                       // Power-on wait and init again
	} lcd_oper_t;

	// Execution wait after the enable pulse falls
	typedef enum logic [2:0] {
		WAIT_SHORT = 3'd0,                       // Data write
		WAIT_CMD   = 3'd1,                       // 42 us
		WAIT_INIT  = 3'd2,                       // 100 us
		WAIT_FUNC  = 3'd3,                       // 4.1 ms
		WAIT_CLEAR = 3'd4                        // 1.64 ms
	} wait_class_t;

	// Sequencer FSM
	typedef enum logic [2:0] {
		SEQ_POWER,                               // Power-on settle
		SEQ_INIT_ISSUE,                          // cmd_start high for a table entry
		SEQ_INIT_WAIT,                           // Bus engine busy with init cmd
		SEQ_IDLE,                                // rdy high
		SEQ_HOST_WAIT                            // Bus engine busy with host cmd
	} seq_state_t;

	// Bus cycle engine FSM
	typedef enum logic [2:0] {
		BUS_IDLE,
		BUS_SETUP,                               // RS settles while E is low
		BUS_STROBE,                              // E high
		BUS_EXEC,                                // E low while the LCD executes
		BUS_DONE                                 // cmd_done pulse
	} bus_state_t;

endpackage

// ==== verif/tb_lcd_ctrl.sv ====
`timescale 1ns/1ps
`include "lcd_params.svh"

module tb_lcd_ctrl;
	import lcd_pkg::*;

	localparam int STEP_TIMEOUT = 500000;     // Cycles allowed per wait
	localparam int N_DATA       = 40;
	localparam int N_INSTR      = 16;
	localparam int N_INIT       = 9;          // Entries in the init table

	logic        CLK;
	logic        RST;
	lcd_byte_t   data;
	lcd_oper_t   oper;
	logic        enb;
	logic        rdy;
	logic        lcd_rs;
	logic        lcd_rw;
	logic        lcd_e;
	lcd_byte_t   lcd_db;

	logic [31:0] rng_state;                   // LCG state
	int          mismatch_cnt;
	int          fail_cnt;
	int          pulse_cnt;                   // Completed enable pulses
	event        run_end;

	// Expected command model with one entry per enable pulse
	lcd_byte_t   exp_byte[$];
	logic        exp_rs[$];
	wait_class_t exp_wait[$];

	// Bus monitor state
	logic        e_prev;
	logic        rdy_prev;
	logic        in_gap;                      // Between a fall and the next rise
	lcd_cyc_t    high_cnt;
	lcd_cyc_t    gap_cnt;
	lcd_cyc_t    gap_min;
	lcd_byte_t   db_hold;

	lcd_ctrl_top lcd_ctrl_top_inst (
		.CLK    (CLK),
		.RST    (RST),
		.data   (data),
		.oper   (oper),
		.enb    (enb),
		.rdy    (rdy),
		.lcd_rs (lcd_rs),
		.lcd_rw (lcd_rw),
		.lcd_e  (lcd_e),
		.lcd_db (lcd_db)
	);

	initial CLK = 1'b0;
	always #2 CLK = ~CLK;                     // 4 ns period

	// ------------------------------------------------------------------------
	// Helpers
	// ------------------------------------------------------------------------

	function automatic logic [31:0] lcg_next();
		rng_state = rng_state * 32'd1664525 + 32'd1013904223;
		return rng_state;
	endfunction

	// Minimum execution wait of each class at 24 MHz
	function automatic lcd_cyc_t min_wait(wait_class_t w);
		case (w)
			WAIT_SHORT: return lcd_cyc_t'(`LCD_E_HIGH_CYC);
			WAIT_CMD:   return lcd_cyc_t'(`LCD_WAIT_CMD_CYC);
			WAIT_INIT:  return lcd_cyc_t'(`LCD_WAIT_INIT_CYC);
			WAIT_CLEAR: return lcd_cyc_t'(`LCD_WAIT_CLEAR_CYC);
			default:    return lcd_cyc_t'(`LCD_WAIT_FUNC_CYC);
		endcase
	endfunction

	task automatic check_byte(string name, lcd_byte_t got, lcd_byte_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_cycles(string name, lcd_cyc_t got, lcd_cyc_t lo);
		if (got < lo) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got 0x%h, expected at least 0x%h at %0t",
				name, got, lo, $time);
		end
	endtask

	task automatic check_count(string name, lcd_cyc_t got, lcd_cyc_t exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic check_flag(string name, logic got, logic exp);
		if (got !== exp) begin
			mismatch_cnt++;
			$display("MISMATCH %s: got 0x%h, expected 0x%h at %0t", name, got, exp, $time);
		end
	endtask

	task automatic report_failure(string what);
		fail_cnt++;
		$display("ERROR: %s at %0t", what, $time);
	endtask

	task automatic stop_on_timeout(string what);
		report_failure(what);
		-> run_end;
		forever @(posedge CLK);                   // Parked until the closing block ends the run
	endtask

	task automatic expect_cmd(lcd_byte_t b, logic rs, wait_class_t w);
		exp_byte.push_back(b);
		exp_rs.push_back(rs);
		exp_wait.push_back(w);
	endtask

	// HD44780 init table with RS low throughout
	task automatic expect_init();
		expect_cmd(`LCD_CMD_SETUP, 1'b0, WAIT_FUNC);
		repeat (3) expect_cmd(`LCD_CMD_SETUP, 1'b0, WAIT_INIT);
		expect_cmd(`LCD_CMD_DISP_OFF, 1'b0, WAIT_CMD);
		expect_cmd(`LCD_CMD_CLEAR, 1'b0, WAIT_CLEAR);
		expect_cmd(`LCD_CMD_ENTRY, 1'b0, WAIT_CMD);
		expect_cmd(`LCD_CMD_DISP_ON, 1'b0, WAIT_CMD);
		expect_cmd(`LCD_CMD_CLEAR, 1'b0, WAIT_CLEAR);
	endtask

	task automatic reset_dut();
		@(posedge CLK);
		RST <= 1'b1;
		repeat (3) @(posedge CLK);                // 3 reset cycles
		RST <= 1'b0;
		@(posedge CLK);
	endtask

	task automatic wait_rdy(string step);
		int n;
		n = 0;
		@(negedge CLK);
		while (rdy !== 1'b1) begin
			if (n == STEP_TIMEOUT)
				stop_on_timeout({"rdy never rose during ", step});
			n++;
			@(negedge CLK);
		end
	endtask

	task automatic wait_e_high(string step);
		int n;
		n = 0;
		@(negedge CLK);
		while (lcd_e !== 1'b1) begin
			if (n == STEP_TIMEOUT)
				stop_on_timeout({"lcd_e never rose during ", step});
			n++;
			@(negedge CLK);
		end
	endtask

	task automatic wait_e_low(string step);
		int n;
		n = 0;
		@(negedge CLK);
		while (lcd_e !== 1'b0) begin
			if (n == STEP_TIMEOUT)
				stop_on_timeout({"lcd_e never fell during ", step});
			n++;
			@(negedge CLK);
		end
	endtask

	// Back at idle with every expected command seen on the bus
	task automatic wait_idle(string step);
		wait_rdy(step);
		if (exp_byte.size() != 0)
			report_failure({"expected commands missing after ", step});
	endtask

	// Power-on wait and init table with a timed wait per pulse edge
	task automatic wait_init(string step);
		repeat (N_INIT) begin
			wait_e_high(step);
			wait_e_low(step);
		end
		wait_idle(step);
	endtask

	// One host request that returns on the accepting edge
	task automatic send_request(lcd_oper_t op, lcd_byte_t b);
		wait_rdy("host request");
		@(posedge CLK);
		enb  <= 1'b1;
		oper <= op;
		data <= b;
		@(posedge CLK);                           // DUT accepts here
		enb  <= 1'b0;
		oper <= OPER_NONE;
		data <= lcd_byte_t'(lcg_next() >> 8);     // Scrambled while the DUT holds its copy
		case (op)
			OPER_DATA:   expect_cmd(b, 1'b1, WAIT_SHORT);
			OPER_INSTR:  expect_cmd(b, 1'b0, WAIT_CMD);
			OPER_REINIT: expect_init();
			default:     ;
		endcase
	endtask

	// ------------------------------------------------------------------------
	// Bus monitor sampling mid-cycle
	// ------------------------------------------------------------------------

	always @(negedge CLK) begin
		if (RST) begin
			exp_byte.delete();                    // Interrupted commands are lost
			exp_rs.delete();
			exp_wait.delete();
			e_prev   = 1'b0;
			rdy_prev = 1'b0;
			in_gap   = 1'b0;
			high_cnt = '0;
			gap_cnt  = '0;
		end else begin
			if (lcd_e) begin
				if (!e_prev) begin                // Rise
					high_cnt = lcd_cyc_t'(1);
					db_hold  = lcd_db;
					if (in_gap)
						check_cycles("wait before lcd_e rise", gap_cnt, gap_min);
					in_gap = 1'b0;
				end else begin
					high_cnt++;
					check_byte("lcd_db while lcd_e high", lcd_db, db_hold);
				end
			end else if (e_prev) begin            // Fall where the LCD latches
				pulse_cnt++;
				check_count("lcd_e pulse width", high_cnt, lcd_cyc_t'(`LCD_E_HIGH_CYC));
				if (exp_byte.size() == 0) begin
					report_failure("enable pulse while no command was expected");
					in_gap = 1'b0;
				end else begin
					check_byte("lcd_db", lcd_db, exp_byte.pop_front());
					check_flag("lcd_rs", lcd_rs, exp_rs.pop_front());
					gap_min = min_wait(exp_wait.pop_front());
					gap_cnt = lcd_cyc_t'(1);
					in_gap  = 1'b1;
				end
			end else if (in_gap) begin
				if (rdy && !rdy_prev) begin
					check_cycles("wait before rdy rise", gap_cnt, gap_min);
					in_gap = 1'b0;
				end else begin
					gap_cnt++;
				end
			end
			e_prev   = lcd_e;
			rdy_prev = rdy;
		end
	end

	// ------------------------------------------------------------------------
	// Stimulus
	// ------------------------------------------------------------------------

	initial begin
		int          snap;
		lcd_byte_t   b;
		logic [31:0] r;
		RST          = 1'b0;
		enb          = 1'b0;
		oper         = OPER_NONE;
		data         = '0;
		rng_state    = 32'h24bf_e3d3;
		mismatch_cnt = 0;
		fail_cnt     = 0;
		pulse_cnt    = 0;

		reset_dut();                              // Reset and power-on init
		@(negedge CLK);
		check_flag("rdy after reset", rdy, 1'b0);
		check_flag("lcd_e after reset", lcd_e, 1'b0);
		check_flag("lcd_rw", lcd_rw, 1'b0);
		expect_init();
		snap = pulse_cnt;
		wait_init("power-on init");
		check_count("init pulse count", lcd_cyc_t'(pulse_cnt - snap), lcd_cyc_t'(N_INIT));

		for (int i = 0; i < N_DATA; i++) begin    // Character writes
			b    = lcd_byte_t'(lcg_next() >> 16);
			snap = pulse_cnt;
			send_request(OPER_DATA, b);
			wait_idle("data write");
			check_count("data write pulses", lcd_cyc_t'(pulse_cnt - snap), lcd_cyc_t'(1));
		end

		for (int i = 0; i < N_INSTR; i++) begin   // Instructions with ignored strobes between
			r    = lcg_next();
			snap = pulse_cnt;
			repeat (r[1:0]) begin
				send_request(OPER_NONE, lcd_byte_t'(r >> 8));
				@(negedge CLK);
				check_flag("rdy after OPER_NONE", rdy, 1'b1);
			end
			b = lcd_byte_t'(lcg_next() >> 16);
			send_request(OPER_INSTR, b);
			wait_idle("instruction write");
			check_count("instruction pulses", lcd_cyc_t'(pulse_cnt - snap), lcd_cyc_t'(1));
		end

		snap = pulse_cnt;                         // Host re-initialization
		send_request(OPER_REINIT, lcd_byte_t'(lcg_next() >> 16));
		@(negedge CLK);
		check_flag("rdy after OPER_REINIT", rdy, 1'b0);
		wait_init("re-initialization");
		check_count("re-init pulse count", lcd_cyc_t'(pulse_cnt - snap), lcd_cyc_t'(N_INIT));

		send_request(OPER_DATA, lcd_byte_t'(lcg_next() >> 16));
		wait_e_high("data write before reset");
		reset_dut();                              // RST in the middle of the pulse
		@(negedge CLK);
		check_flag("rdy after mid-write reset", rdy, 1'b0);
		check_flag("lcd_e after mid-write reset", lcd_e, 1'b0);
		check_flag("lcd_rs after mid-write reset", lcd_rs, 1'b0);
		check_byte("lcd_db after mid-write reset", lcd_db, 8'h00);
		expect_init();
		snap = pulse_cnt;
		wait_init("init after mid-write reset");
		check_count("init pulse count after reset", lcd_cyc_t'(pulse_cnt - snap),
			lcd_cyc_t'(N_INIT));
		-> run_end;
	end

	initial begin
		@(run_end);
		$display("Error summary: %0d mismatches, %0d other failures", mismatch_cnt, fail_cnt);
		if (mismatch_cnt == 0 && fail_cnt == 0)
			$display("Test completed successfully");
		else
			$display("Test failed");
		$finish;
	end

endmodule
